// File: hw/mult_data_pkg.sv
`default_nettype none

// width types shared by the whole datapath
package mult_data_pkg;

  ////////////////////////////////////////////////////////////////////
  // datapath words
  ////////////////////////////////////////////////////////////////////

  // operand and result word
  typedef logic [31:0] word_t;

  // running sum of the high-half MAC
  // 17x17 product plus 33-bit accumulator with carry
  typedef logic [33:0] wide_t;

  ////////////////////////////////////////////////////////////////////
  // subword lanes
  ////////////////////////////////////////////////////////////////////

  // halfword for 16-bit lanes and mulh partial products
  typedef logic [15:0] half_t;

  // 8-bit dot-product lane
  typedef logic [7:0] byte_t;

endpackage

`default_nettype wire

// File: hw/mult_op_pkg.sv
`default_nettype none

// operator codes and sequencer states
package mult_op_pkg;

  ////////////////////////////////////////////////////////////////////
  // request operator
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_MAC   = 3'd0,
    OP_MSU   = 3'd1,
    OP_MULH  = 3'd2,
    OP_DOT8  = 3'd3,
    OP_DOT16 = 3'd4
  } mult_op_e;

  // signedness select
  // bit 0 marks operand a signed, bit 1 marks operand b signed
  // 2'b10 is not a legal mulh encoding
  typedef logic [1:0] sign_sel_t;

  ////////////////////////////////////////////////////////////////////
  // high-half sequencer
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    MH_IDLE   = 3'd0,
    MH_STEP0  = 3'd1,
    MH_STEP1  = 3'd2,
    MH_STEP2  = 3'd3,
    MH_FINISH = 3'd4
  } mulh_step_e;

endpackage

`default_nettype wire

// File: hw/mult_issue.sv
`timescale 1ns/10ps
`default_nettype none

// single-entry request register in front of the engines
module mult_issue
  import mult_data_pkg::*;
  import mult_op_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       req_valid_i,
  input  mult_op_e  req_op_i,
  input  sign_sel_t req_sign_i,
  input  word_t     req_a_i,
  input  word_t     req_b_i,
  input  word_t     req_c_i,
  input  wire       iss_take_i,
  output logic      req_ready_o,
  output logic      iss_valid_o,
  output mult_op_e  iss_op_o,
  output sign_sel_t iss_sign_o,
  output word_t     iss_a_o,
  output word_t     iss_b_o,
  output word_t     iss_c_o
);

  logic accept;

  // free slot, or the held request leaves on this edge
  assign req_ready_o = ~iss_valid_o | iss_take_i;
  assign accept      = req_valid_i & req_ready_o;

  // valid flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iss_valid_o <= 1'b0;
    end else if (accept) begin
      iss_valid_o <= 1'b1;
    end else if (iss_take_i) begin
      iss_valid_o <= 1'b0;
    end
  end

  // payload, refilled on the draining edge too
  always_ff @(posedge clk) begin
    if (accept) begin
      iss_op_o   <= req_op_i;
      iss_sign_o <= req_sign_i;
      iss_a_o    <= req_a_i;
      iss_b_o    <= req_b_i;
      iss_c_o    <= req_c_i;
    end
  end

  // mulh has no b-signed/a-unsigned form
  a_mulh_sign: assert property (@(posedge clk) disable iff (!rst_n)
    (accept && (req_op_i == OP_MULH)) |-> (req_sign_i != 2'b10));

  // held request frozen until mult_result takes it
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (iss_valid_o && !iss_take_i) |=>
      (iss_valid_o && $stable({iss_op_o, iss_sign_o, iss_a_o, iss_b_o, iss_c_o})));

endmodule

`default_nettype wire

// File: hw/mult_mac32.sv
`timescale 1ns/10ps
`default_nettype none

// full-word multiply-accumulate and multiply-subtract
module mult_mac32
  import mult_data_pkg::*;
  import mult_op_pkg::*;
(
  input  mult_op_e iss_op_i,
  input  word_t    iss_a_i,
  input  word_t    iss_b_i,
  input  word_t    iss_c_i,
  output word_t    mac_result_o
);

  ////////////////////////////////////////////////////////////////////
  // msu folding
  ////////////////////////////////////////////////////////////////////

  logic  is_msu;
  word_t a_msu;
  word_t b_corr;

  assign is_msu = (iss_op_i == OP_MSU);

  // ~a * b + b equals -a * b modulo 2^32
  // so one multiplier serves both operators
  assign a_msu  = iss_a_i ^ {32{is_msu}};

  // correction term only for msu
  assign b_corr = iss_b_i & {32{is_msu}};

  ////////////////////////////////////////////////////////////////////
  // multiply and add
  ////////////////////////////////////////////////////////////////////

  // low word is sign-agnostic, no extension needed
  assign mac_result_o = iss_c_i + b_corr + a_msu * iss_b_i;

endmodule

`default_nettype wire

// File: hw/mult_mulh.sv
`timescale 1ns/10ps
`default_nettype none

// high-half multiply over four 16x16 partial products
module mult_mulh
  import mult_data_pkg::*;
  import mult_op_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       iss_valid_i,
  input  mult_op_e  iss_op_i,
  input  sign_sel_t iss_sign_i,
  input  word_t     iss_a_i,
  input  word_t     iss_b_i,
  input  wire       iss_take_i,
  output logic      mh_done_o,
  output word_t     mh_result_o
);

  mulh_step_e mh_state;
  mulh_step_e mh_next;

  // step controls
  logic hi_a;
  logic hi_b;
  logic sgn_a;
  logic sgn_b;
  logic use_acc;
  logic arith;
  logic shift16;
  logic acc_en;
  logic carry_save;
  logic carry_clear;

  // datapath
  half_t       half_a;
  half_t       half_b;
  logic [16:0] mh_op_a;
  logic [16:0] mh_op_b;
  wide_t       mh_prod;
  wide_t       mh_c;
  wide_t       mh_sum;
  wide_t       mh_shin;
  wide_t       mh_shout;
  logic [4:0]  mh_imm;
  word_t       acc_q;
  logic        carry_q;

  ////////////////////////////////////////////////////////////////////
  // partial product MAC
  ////////////////////////////////////////////////////////////////////

  assign half_a = hi_a ? iss_a_i[31:16] : iss_a_i[15:0];
  assign half_b = hi_b ? iss_b_i[31:16] : iss_b_i[15:0];

  // 17th bit is the sign only for a signed high half
  assign mh_op_a = {sgn_a & half_a[15], half_a};
  assign mh_op_b = {sgn_b & half_b[15], half_b};

  // signed 17x17, fits in 34 bits
  assign mh_prod = {{17{mh_op_a[16]}}, mh_op_a} * {{17{mh_op_b[16]}}, mh_op_b};

  // previous step plus saved carry, sign-extended from 33 bits
  assign mh_c   = use_acc ? {{2{carry_q}}, acc_q} : '0;
  assign mh_sum = mh_c + mh_prod;

  // upper two bits only survive an arithmetic shift
  assign mh_shin  = {arith & mh_sum[33], arith & mh_sum[32], mh_sum[31:0]};
  assign mh_imm   = shift16 ? 5'd16 : 5'd0;
  assign mh_shout = $signed(mh_shin) >>> mh_imm;

  assign mh_result_o = mh_shout[31:0];
  assign mh_done_o   = (mh_state == MH_FINISH);

  ////////////////////////////////////////////////////////////////////
  // step sequencer
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    mh_next     = mh_state;
    hi_a        = 1'b0;
    hi_b        = 1'b0;
    sgn_a       = 1'b0;
    sgn_b       = 1'b0;
    use_acc     = 1'b1;
    arith       = 1'b0;
    shift16     = 1'b0;
    acc_en      = 1'b0;
    carry_save  = 1'b0;
    carry_clear = 1'b0;
    case (mh_state)
      MH_IDLE: begin
        use_acc = 1'b0;
        if (iss_valid_i && (iss_op_i == OP_MULH)) begin
          mh_next = MH_STEP0;
        end
      end
      MH_STEP0: begin
        // al*bl unsigned, never overflows
        use_acc = 1'b0;
        shift16 = 1'b1;
        acc_en  = 1'b1;
        mh_next = MH_STEP1;
      end
      MH_STEP1: begin
        // al*bh signed iff b is signed
        hi_b       = 1'b1;
        sgn_b      = iss_sign_i[1];
        arith      = 1'b1;
        acc_en     = 1'b1;
        carry_save = 1'b1;
        mh_next    = MH_STEP2;
      end
      MH_STEP2: begin
        // ah*bl signed iff a is signed
        // bits 33:32 shift back in, carry no longer needed
        hi_a        = 1'b1;
        sgn_a       = iss_sign_i[0];
        arith       = 1'b1;
        shift16     = 1'b1;
        acc_en      = 1'b1;
        carry_save  = 1'b1;
        carry_clear = 1'b1;
        mh_next     = MH_FINISH;
      end
      MH_FINISH: begin
        // ah*bh lands in the high word
        hi_a  = 1'b1;
        hi_b  = 1'b1;
        sgn_a = iss_sign_i[0];
        sgn_b = iss_sign_i[1];
        if (iss_take_i) begin
          mh_next = MH_IDLE;
        end
      end
      default: begin
        mh_next = MH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mh_state <= MH_IDLE;
      carry_q  <= 1'b0;
    end else begin
      mh_state <= mh_next;
      if (carry_save) begin
        carry_q <= ~carry_clear & mh_sum[32];
      end else if (iss_take_i) begin
        carry_q <= 1'b0;
      end
    end
  end

  // running sum between steps
  always_ff @(posedge clk) begin
    if (acc_en) begin
      acc_q <= mh_shout[31:0];
    end
  end

  // sequence runs only under a held mulh request
  a_mulh_held: assert property (@(posedge clk) disable iff (!rst_n)
    (mh_state != MH_IDLE) |-> (iss_valid_i && (iss_op_i == OP_MULH)));

endmodule

`default_nettype wire

// File: hw/mult_dot.sv
`timescale 1ns/10ps
`default_nettype none

// 8-bit and 16-bit dot products with accumulate
module mult_dot
  import mult_data_pkg::*;
  import mult_op_pkg::*;
(
  input  mult_op_e  iss_op_i,
  input  sign_sel_t iss_sign_i,
  input  word_t     iss_a_i,
  input  word_t     iss_b_i,
  input  word_t     iss_c_i,
  output word_t     dot_result_o
);

  word_t prod8  [4];
  word_t prod16 [2];
  word_t dot8;
  word_t dot16;

  ////////////////////////////////////////////////////////////////////
  // four byte lanes
  ////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 4; i++) begin : g_lane8
    byte_t lane_a;
    byte_t lane_b;
    word_t ext_a;
    word_t ext_b;

    assign lane_a = iss_a_i[8*i +: 8];
    assign lane_b = iss_b_i[8*i +: 8];

    // extend per sign select, product exact in 32 bits
    assign ext_a    = {{24{iss_sign_i[0] & lane_a[7]}}, lane_a};
    assign ext_b    = {{24{iss_sign_i[1] & lane_b[7]}}, lane_b};
    assign prod8[i] = ext_a * ext_b;
  end

  assign dot8 = iss_c_i + prod8[0] + prod8[1] + prod8[2] + prod8[3];

  ////////////////////////////////////////////////////////////////////
  // two halfword lanes
  ////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : g_lane16
    half_t lane_a;
    half_t lane_b;
    word_t ext_a;
    word_t ext_b;

    assign lane_a = iss_a_i[16*i +: 16];
    assign lane_b = iss_b_i[16*i +: 16];

    // unsigned 16x16 can reach 32 bits, kept modulo 2^32
    assign ext_a     = {{16{iss_sign_i[0] & lane_a[15]}}, lane_a};
    assign ext_b     = {{16{iss_sign_i[1] & lane_b[15]}}, lane_b};
    assign prod16[i] = ext_a * ext_b;
  end

  assign dot16 = iss_c_i + prod16[0] + prod16[1];

  // lane width by operator
  assign dot_result_o = (iss_op_i == OP_DOT16) ? dot16 : dot8;

endmodule

`default_nettype wire

// File: hw/mult_result.sv
`timescale 1ns/10ps
`default_nettype none

// result select and response register
module mult_result
  import mult_data_pkg::*;
  import mult_op_pkg::*;
(
  input  wire      clk,
  input  wire      rst_n,
  input  wire      iss_valid_i,
  input  mult_op_e iss_op_i,
  input  word_t    mac_result_i,
  input  wire      mh_done_i,
  input  word_t    mh_result_i,
  input  word_t    dot_result_i,
  input  wire      rsp_ready_i,
  output logic     iss_take_o,
  output logic     rsp_valid_o,
  output word_t    rsp_result_o
);

  logic  complete;
  word_t sel_result;

  ////////////////////////////////////////////////////////////////////
  // completion and select
  ////////////////////////////////////////////////////////////////////

  // mulh waits for the sequencer, the rest is combinational
  assign complete = iss_valid_i & ((iss_op_i != OP_MULH) | mh_done_i);

  // load when the slot is empty or being drained
  assign iss_take_o = complete & (~rsp_valid_o | rsp_ready_i);

  always_comb begin
    sel_result = mac_result_i;
    case (iss_op_i)
      OP_MAC, OP_MSU:    sel_result = mac_result_i;
      OP_MULH:           sel_result = mh_result_i;
      OP_DOT8, OP_DOT16: sel_result = dot_result_i;
      default:           sel_result = mac_result_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // response register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_o <= 1'b0;
    end else if (iss_take_o) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_take_o) begin
      rsp_result_o <= sel_result;
    end
  end

  // stalled response holds until the consumer takes it
  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_result_o)));

endmodule

`default_nettype wire

// File: hw/mult_top.sv
`timescale 1ns/10ps
`default_nettype none

// multiply and MAC unit with request and response channels
module mult_top
  import mult_data_pkg::*;
  import mult_op_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  // request channel
  input  wire       req_valid_i,
  output logic      req_ready_o,
  input  mult_op_e  req_op_i,
  input  sign_sel_t req_sign_i,
  input  word_t     req_a_i,
  input  word_t     req_b_i,
  input  word_t     req_c_i,
  // response channel
  output logic      rsp_valid_o,
  input  wire       rsp_ready_i,
  output word_t     rsp_result_o
);

  // held request
  logic      iss_valid;
  mult_op_e  iss_op;
  sign_sel_t iss_sign;
  word_t     iss_a;
  word_t     iss_b;
  word_t     iss_c;
  logic      iss_take;

  // engine results
  word_t mac_result;
  word_t mh_result;
  logic  mh_done;
  word_t dot_result;

  ////////////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////////////

  mult_issue u_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_sign_i  (req_sign_i),
    .req_a_i     (req_a_i),
    .req_b_i     (req_b_i),
    .req_c_i     (req_c_i),
    .iss_take_i  (iss_take),
    .req_ready_o (req_ready_o),
    .iss_valid_o (iss_valid),
    .iss_op_o    (iss_op),
    .iss_sign_o  (iss_sign),
    .iss_a_o     (iss_a),
    .iss_b_o     (iss_b),
    .iss_c_o     (iss_c)
  );

  ////////////////////////////////////////////////////////////////////
  // engines
  ////////////////////////////////////////////////////////////////////

  mult_mac32 u_mac32 (
    .iss_op_i     (iss_op),
    .iss_a_i      (iss_a),
    .iss_b_i      (iss_b),
    .iss_c_i      (iss_c),
    .mac_result_o (mac_result)
  );

  mult_mulh u_mulh (
    .clk         (clk),
    .rst_n       (rst_n),
    .iss_valid_i (iss_valid),
    .iss_op_i    (iss_op),
    .iss_sign_i  (iss_sign),
    .iss_a_i     (iss_a),
    .iss_b_i     (iss_b),
    .iss_take_i  (iss_take),
    .mh_done_o   (mh_done),
    .mh_result_o (mh_result)
  );

  mult_dot u_dot (
    .iss_op_i     (iss_op),
    .iss_sign_i   (iss_sign),
    .iss_a_i      (iss_a),
    .iss_b_i      (iss_b),
    .iss_c_i      (iss_c),
    .dot_result_o (dot_result)
  );

  // output side
  mult_result u_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .iss_valid_i  (iss_valid),
    .iss_op_i     (iss_op),
    .mac_result_i (mac_result),
    .mh_done_i    (mh_done),
    .mh_result_i  (mh_result),
    .dot_result_i (dot_result),
    .rsp_ready_i  (rsp_ready_i),
    .iss_take_o   (iss_take),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_result_o (rsp_result_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

// free-running 25 MHz clock and power-on reset
module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // reset low for ten rising edges, released off the edge
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/tb_mult.sv
`timescale 1ns/10ps
`default_nettype none

// directed tests for the multiply and MAC unit
module tb_mult
  import mult_data_pkg::*;
  import mult_op_pkg::*;
;

  localparam logic [31:0] SEED = 32'h7511;

  // request counts per test, used to size the watchdog
  localparam int N_MACSU = 40;
  localparam int N_MULH  = 3 * (25 + 10);
  localparam int N_DOT   = 2 * 4 * 6;
  localparam int N_LAT   = 2;
  localparam int N_BP    = 60;
  localparam int N_TOTAL = N_MACSU + N_MULH + N_DOT + N_LAT + N_BP;
  localparam int WATCHDOG_CYCLES = 10 + 20 * N_TOTAL;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  logic      req_ready;
  mult_op_e  req_op;
  sign_sel_t req_sign;
  word_t     req_a;
  word_t     req_b;
  word_t     req_c;
  logic      rsp_valid;
  logic      rsp_ready;
  word_t     rsp_result;

  // scoreboard, one entry per accepted request
  word_t    exp_q [$];
  string    name_q [$];

  logic [31:0] rng_state;
  logic [31:0] ready_state;
  int          err_count;
  logic        held_stall;
  word_t       held_result;
  logic        bp_done;

  tb_clock u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mult_top u_mult_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_op_i     (req_op),
    .req_sign_i   (req_sign),
    .req_a_i      (req_a),
    .req_b_i      (req_b),
    .req_c_i      (req_c),
    .rsp_valid_o  (rsp_valid),
    .rsp_ready_i  (rsp_ready),
    .rsp_result_o (rsp_result)
  );

  //////////////////////////////////////////////////////////////////////
  // random numbers and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // low field of x, widened to 64 bits as signed or unsigned
  function automatic logic [63:0] extend_lane(input word_t x, input int width,
                                              input logic sgn);
    logic [63:0] mask;
    logic [63:0] v;
    mask = (64'd1 << width) - 64'd1;
    v    = {32'd0, x} & mask;
    if (sgn && x[width-1]) begin
      v = v | ~mask;
    end
    return v;
  endfunction

  function automatic word_t ref_result(input mult_op_e op, input sign_sel_t sg,
                                       input word_t a, input word_t b, input word_t c);
    logic [63:0] acc;
    logic [63:0] prod;
    acc  = {32'd0, c};
    prod = {32'd0, a} * {32'd0, b};
    case (op)
      OP_MAC: acc = acc + prod;
      OP_MSU: acc = acc - prod;
      OP_MULH: begin
        // upper word of the full 64-bit product
        prod = extend_lane(a, 32, sg[0]) * extend_lane(b, 32, sg[1]);
        acc  = {32'd0, prod[63:32]};
      end
      OP_DOT8: begin
        for (int k = 0; k < 4; k++) begin
          acc = acc + extend_lane(a >> (8 * k), 8, sg[0]) * extend_lane(b >> (8 * k), 8, sg[1]);
        end
      end
      OP_DOT16: begin
        for (int k = 0; k < 2; k++) begin
          acc = acc + extend_lane(a >> (16 * k), 16, sg[0])
                    * extend_lane(b >> (16 * k), 16, sg[1]);
        end
      end
      default: acc = 64'd0;
    endcase
    return acc[31:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    err_count++;
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      abort_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // request driver and response monitor
  //////////////////////////////////////////////////////////////////////

  // move to the drive slot just after a rising edge
  task automatic step_to_drive();
    @(posedge clk);
    #2;
  endtask

  // entered in the drive slot, returns in the drive slot after the transfer
  task automatic send_request(input string name, input mult_op_e op, input sign_sel_t sg,
                              input word_t a, input word_t b, input word_t c);
    logic taken;
    taken     = 1'b0;
    req_valid = 1'b1;
    req_op    = op;
    req_sign  = sg;
    req_a     = a;
    req_b     = b;
    req_c     = c;
    exp_q.push_back(ref_result(op, sg, a, b, c));
    name_q.push_back(name);
    // ready is settled at the falling edge, transfer on the next rising one
    while (!taken) begin
      @(negedge clk);
      taken = req_ready;
    end
    step_to_drive();
    req_valid = 1'b0;
  endtask

  task automatic drain_responses();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    step_to_drive();
  endtask

  // outputs sampled mid-cycle, a transfer completes on the next rising edge
  always @(negedge clk) begin
    word_t    exp;
    string    name;
    if (rst_n) begin
      if (held_stall) begin
        check_bit("stalled rsp_valid_o", 1'b1, rsp_valid);
        check_word("stalled rsp_result_o", held_result, rsp_result);
      end
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("a response arrived with no request outstanding");
        end else begin
          exp  = exp_q.pop_front();
          name = name_q.pop_front();
          check_word(name, exp, rsp_result);
        end
      end
      held_stall  = rsp_valid && !rsp_ready;
      held_result = rsp_result;
    end
  end

  // whole run bounded by the number of requests
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("timeout after %0d cycles, the DUT stopped responding",
                        WATCHDOG_CYCLES));
  end

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    @(negedge clk);
    check_bit("reset req_ready_o", 1'b1, req_ready);
    check_bit("reset rsp_valid_o", 1'b0, rsp_valid);
  endtask

  task automatic mac_msu_sweep();
    word_t    a;
    word_t    b;
    word_t    c;
    mult_op_e op;
    for (int i = 0; i < N_MACSU; i++) begin
      a  = next_rand();
      b  = next_rand();
      c  = next_rand();
      op = ((i % 2) != 0) ? OP_MSU : OP_MAC;
      send_request("mac_msu", op, 2'b00, a, b, c);
    end
    drain_responses();
  endtask

  task automatic mulh_corners();
    word_t     corner [5];
    sign_sel_t sels [3];
    word_t     a;
    word_t     b;
    corner = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
    // mulh legal forms: signed x signed, signed a x unsigned b, unsigned x unsigned
    sels   = '{2'b11, 2'b01, 2'b00};
    for (int s = 0; s < 3; s++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          send_request("mulh_corner", OP_MULH, sels[s], corner[i], corner[j], 32'd0);
        end
      end
      for (int k = 0; k < 10; k++) begin
        a = next_rand();
        b = next_rand();
        send_request("mulh_random", OP_MULH, sels[s], a, b, 32'd0);
      end
    end
    drain_responses();
  endtask

  task automatic dot_sweep();
    word_t    a;
    word_t    b;
    word_t    c;
    mult_op_e op;
    for (int o = 0; o < 2; o++) begin
      op = (o == 0) ? OP_DOT8 : OP_DOT16;
      for (int s = 0; s < 4; s++) begin
        for (int k = 0; k < 6; k++) begin
          a = next_rand();
          b = next_rand();
          c = next_rand();
          send_request("dot", op, sign_sel_t'(s), a, b, c);
        end
      end
    end
    drain_responses();
  endtask

  // cycles from the accepting edge to the edge that raises rsp_valid_o
  task automatic latency_probe(input string name, input mult_op_e op, input int exp_cycles);
    int    cycles;
    word_t a;
    word_t b;
    word_t c;
    a = next_rand();
    b = next_rand();
    c = next_rand();
    send_request(name, op, 2'b11, a, b, c);
    cycles = 0;
    @(negedge clk);
    while (!rsp_valid && cycles < 50) begin
      cycles++;
      @(negedge clk);
    end
    check_count(name, exp_cycles, cycles);
    drain_responses();
  endtask

  task automatic backpressure_mix();
    logic [31:0] r;
    mult_op_e    op;
    sign_sel_t   sg;
    word_t       a;
    word_t       b;
    word_t       c;
    bp_done = 1'b0;
    fork
      begin
        for (int i = 0; i < N_BP; i++) begin
          r  = next_rand();
          op = mult_op_e'(r[2:0] % 3'd5);
          sg = sign_sel_t'(r[4:3]);
          // mulh has no unsigned a x signed b form
          if (op == OP_MULH && sg == 2'b10) begin
            sg = 2'b11;
          end
          a = next_rand();
          b = next_rand();
          c = next_rand();
          send_request("backpressure", op, sg, a, b, c);
        end
        bp_done = 1'b1;
      end
      begin
        // consumer stalls on roughly half the cycles
        while (1) begin
          @(negedge clk);
          if (bp_done) begin
            break;
          end
          step_to_drive();
          ready_state = xorshift32(ready_state);
          rsp_ready   = ready_state[7];
        end
      end
    join
    step_to_drive();
    rsp_ready = 1'b1;
    drain_responses();
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    req_valid   = 1'b0;
    req_op      = OP_MAC;
    req_sign    = 2'b00;
    req_a       = '0;
    req_b       = '0;
    req_c       = '0;
    rsp_ready   = 1'b1;
    rng_state   = SEED;
    ready_state = SEED ^ 32'h5A5A_0000;
    err_count   = 0;
    held_stall  = 1'b0;
    held_result = '0;
    bp_done     = 1'b0;

    @(posedge rst_n);
    reset_state();
    step_to_drive();
    mac_msu_sweep();
    mulh_corners();
    dot_sweep();
    latency_probe("latency_mac", OP_MAC, 1);
    latency_probe("latency_mulh", OP_MULH, 5);
    backpressure_mix();

    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hw/mult_data_pkg.sv
hw/mult_op_pkg.sv
hw/mult_issue.sv
hw/mult_mac32.sv
hw/mult_mulh.sv
hw/mult_dot.sv
hw/mult_result.sv
hw/mult_top.sv
bench/tb_clock.sv
bench/tb_mult.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the multiply unit testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_mult \
  -Mdir obj_dir \
  -f flist.f

# keep the output for the verdict even when the run stops early
sim_out=$(./obj_dir/Vtb_mult 2>&1 || true)
printf '%s\n' "$sim_out"

if grep -qx 'Test OK' <<< "$sim_out"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
